/* dv/tb_minimig_glue.sv */
// system glue testbench
// reference model of the register map, reset sequencer, sample timer and irq encoder
`timescale 1ns/1ns
`default_nettype none

module tb_minimig_glue
	import glue_pkg::*;
();

	localparam int unsigned CLK_HZ       = 1000;
	localparam int unsigned SAMPLE_HZ    = 77;
	localparam int unsigned RESET_FRAMES = 3;
	localparam bit          NTSC_DEF     = 1'b1;
	localparam int          ACK_TIMEOUT  = 20;   // cycles
	localparam int          RUN_TIMEOUT  = 10;   // frames

	// dut inputs
	logic        clk;
	logic        reset;
	logic        wb_cyc_i, wb_stb_i, wb_we_i;
	wb_adr_t     wb_adr_i;
	wb_data_t    wb_dat_i;
	logic [63:0] rtc_i;
	logic        ovl_i;
	logic        ext_rst_i, kbd_rst_i, kbd_reset_n_i, cpu_reset_in_n_i, sof_i;
	logic [5:0]  irq_req_i;
	logic        nmi_i, vsync_n_i, hblank_i, led_n_i;

	// dut outputs
	wire          wb_ack_o;
	wb_data_t     wb_dat_o;
	mem_cfg_t     memory_config_o;
	chipset_cfg_t chipset_config_o;
	cpu_cfg_t     cpu_config_o;
	floppy_cfg_t  floppy_config_o;
	ide_cfg_t     ide_config0_o, ide_config1_o;
	wire          turbochipram_o, turbokick_o, aga_o;
	wire  [1:0]   slow_config_o;
	wire          rst_o, cpu_reset_n_o, cen_44100_o;
	ipl_t         ipl_n_o;
	wire          init_b_o, ntsc_o, pwr_led_o;

	int          errors = 0;
	int          checks = 0;
	logic [31:0] seed;                                  // main thread random state
	logic [31:0] bg_seed = 32'd79714 ^ 32'h9e37_79b9;  // background random state

	// reference model state
	logic         model_valid = 1'b0;
	logic         ack_m, usr_m, dim_m, cen_m, ntsc_m;
	mem_cfg_t     mem_m;
	chipset_cfg_t chip_m;
	cpu_cfg_t     cpu_m;
	floppy_cfg_t  flop_m;
	ide_cfg_t     ide0_m, ide1_m;
	rst_state_t   st_m;
	logic [3:0]   cnt_m;   // frames since release
	logic [31:0]  acc_m;
	ipl_t         ipl_m;
	wire          wr_m, rst_req_m, rst_exp;
	wire  [31:0]  acc_nxt;

	minimig_glue #(
		.CLK_HZ       (CLK_HZ),
		.SAMPLE_HZ    (SAMPLE_HZ),
		.RESET_FRAMES (RESET_FRAMES),
		.NTSC_DEFAULT (NTSC_DEF)
	) minimig_glue_i (.*);

	always #50 clk = ~clk;

	// ------------------------------------------------------------------------
	// reference functions
	// ------------------------------------------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// highest level wins, nmi is level 7
	function automatic ipl_t ipl_ref(input logic [5:0] req, input logic nmi);
		if (nmi)
			return 3'b000;
		for (int k = 5; k >= 0; k--) begin
			if (req[k])
				return ~ipl_t'(k + 1);
		end
		return 3'b111;
	endfunction

	function automatic logic pwr_led_ref(input logic led_n, input logic hbl, input logic dim_n);
		if (dim_n)
			return ~led_n;
		return !(led_n && !hbl);  // off state glows in hblank
	endfunction

	// bits of each register word that read back
	function automatic wb_data_t read_mask(input wb_adr_t adr);
		case (adr)
			REG_MEMORY:  return 16'h007f;
			REG_CHIPSET: return 16'h001f;
			REG_CPU:     return 16'h000f;
			REG_FLOPPY:  return 16'h000f;
			REG_IDE:     return 16'h003f;
			REG_MISC:    return 16'h0002;  // reset request reads 0
			default:     return 16'h0000;
		endcase
	endfunction

	// ------------------------------------------------------------------------
	// reference model, advances on the same edges as the dut
	// ------------------------------------------------------------------------
	assign wr_m      = wb_cyc_i & wb_stb_i & ~ack_m & wb_we_i & (wb_adr_i <= REG_MISC);
	assign rst_req_m = ext_rst_i | kbd_rst_i | usr_m | ~kbd_reset_n_i;
	assign rst_exp   = (st_m != RST_RUN) | ~cpu_reset_in_n_i;
	assign acc_nxt   = acc_m + SAMPLE_HZ;

	always @(posedge clk) begin
		if (reset) begin
			model_valid <= 1'b1;
			ack_m  <= 1'b0;
			usr_m  <= 1'b0;
			dim_m  <= 1'b0;
			mem_m  <= '0;
			chip_m <= '0;
			cpu_m  <= '0;
			flop_m <= '0;
			ide0_m <= '0;
			ide1_m <= '0;
			st_m   <= RST_HOLD;
			cnt_m  <= '0;
			acc_m  <= '0;
			cen_m  <= 1'b0;
			ipl_m  <= 3'b111;
			ntsc_m <= NTSC_DEF;
		end else begin
			ack_m <= wb_cyc_i & wb_stb_i & ~ack_m;
			usr_m <= 1'b0;
			if (wr_m) begin
				case (wb_adr_i)
					REG_MEMORY:  mem_m  <= wb_dat_i[6:0];
					REG_CHIPSET: chip_m <= wb_dat_i[4:0];
					REG_CPU:     cpu_m  <= wb_dat_i[3:0];
					REG_FLOPPY:  flop_m <= wb_dat_i[3:0];
					REG_IDE: begin
						ide0_m <= wb_dat_i[2:0];
						ide1_m <= wb_dat_i[5:3];
					end
					default: begin
						usr_m <= wb_dat_i[0];
						dim_m <= wb_dat_i[1];
					end
				endcase
			end
			// reset sequencer
			if (rst_req_m) begin
				st_m  <= RST_HOLD;
				cnt_m <= '0;
			end else if (st_m == RST_HOLD) begin
				st_m <= RST_COUNT;
			end else if (st_m == RST_COUNT && sof_i) begin
				cnt_m <= cnt_m + 1'b1;
				if (cnt_m + 1 == RESET_FRAMES)
					st_m <= RST_RUN;
			end
			// sample timer
			cen_m <= (acc_nxt >= CLK_HZ);
			acc_m <= (acc_nxt >= CLK_HZ) ? acc_nxt - CLK_HZ : acc_nxt;
			ipl_m <= ipl_ref(irq_req_i, nmi_i);
			if (rst_exp)
				ntsc_m <= chip_m[1];  // mode latched only in reset
		end
	end

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		errors++;
		$display("Error: %s = %0h, expected %0h", name, got, exp);
	endtask

	// ------------------------------------------------------------------------
	// compare, on the falling edge where everything has settled
	// ------------------------------------------------------------------------
	always @(negedge clk) begin
		if (model_valid) begin
			checks++;
			if (wb_ack_o !== ack_m) report_mismatch("wb_ack_o", wb_ack_o, ack_m);
			if (memory_config_o !== mem_m)
				report_mismatch("memory_config_o", memory_config_o, mem_m);
			if (chipset_config_o !== chip_m)
				report_mismatch("chipset_config_o", chipset_config_o, chip_m);
			if (cpu_config_o !== cpu_m) report_mismatch("cpu_config_o", cpu_config_o, cpu_m);
			if (floppy_config_o !== flop_m)
				report_mismatch("floppy_config_o", floppy_config_o, flop_m);
			if (ide_config0_o !== ide0_m) report_mismatch("ide_config0_o", ide_config0_o, ide0_m);
			if (ide_config1_o !== ide1_m) report_mismatch("ide_config1_o", ide_config1_o, ide1_m);
			// derived flags
			if (turbochipram_o !== (~ovl_i & cpu_m[2] & (mem_m[1:0] == 2'd3)))
				report_mismatch("turbochipram_o", turbochipram_o,
					~ovl_i & cpu_m[2] & (mem_m[1:0] == 2'd3));
			if (turbokick_o !== (~ovl_i & cpu_m[3]))
				report_mismatch("turbokick_o", turbokick_o, ~ovl_i & cpu_m[3]);
			if (aga_o !== chip_m[4]) report_mismatch("aga_o", aga_o, chip_m[4]);
			if (slow_config_o !== mem_m[3:2])
				report_mismatch("slow_config_o", slow_config_o, mem_m[3:2]);
			// reset, timing, irq, video
			if (rst_o !== rst_exp) report_mismatch("rst_o", rst_o, rst_exp);
			if (cpu_reset_n_o !== (st_m == RST_RUN))
				report_mismatch("cpu_reset_n_o", cpu_reset_n_o, st_m == RST_RUN);
			if (cen_44100_o !== cen_m) report_mismatch("cen_44100_o", cen_44100_o, cen_m);
			if (ipl_n_o !== ipl_m) report_mismatch("ipl_n_o", ipl_n_o, ipl_m);
			if (ntsc_o !== ntsc_m) report_mismatch("ntsc_o", ntsc_o, ntsc_m);
			if (pwr_led_o !== pwr_led_ref(led_n_i, hblank_i, dim_m))
				report_mismatch("pwr_led_o", pwr_led_o, pwr_led_ref(led_n_i, hblank_i, dim_m));
		end
	end

	// background traffic on irq and led lines
	always @(posedge clk) begin
		bg_seed   <= xorshift(bg_seed);
		irq_req_i <= bg_seed[5:0] & bg_seed[11:6];  // sparse requests
		nmi_i     <= (bg_seed[19:16] == 4'd0);
		led_n_i   <= bg_seed[20];
		hblank_i  <= bg_seed[21];
	end

	// ------------------------------------------------------------------------
	// host and frame tasks
	// ------------------------------------------------------------------------
	task automatic wait_ack(input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (!wb_ack_o && n < ACK_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!wb_ack_o) begin
			errors++;
			$display("no wishbone ack for the %s within %0d cycles", what, ACK_TIMEOUT);
		end
	endtask

	task automatic wb_write(input wb_adr_t adr, input wb_data_t dat);
		@(posedge clk);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i  <= 1'b1;
		wb_adr_i <= adr;
		wb_dat_i <= dat;
		wait_ack("write");
		@(posedge clk);
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
	endtask

	task automatic wb_read(input wb_adr_t adr, output wb_data_t dat);
		@(posedge clk);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i  <= 1'b0;
		wb_adr_i <= adr;
		wait_ack("read");
		dat = wb_dat_o;  // valid with ack
		@(posedge clk);
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
	endtask

	// one sof pulse, returns on the falling edge after it was sampled
	task automatic pulse_sof();
		@(posedge clk);
		sof_i <= 1'b1;
		@(posedge clk);
		sof_i <= 1'b0;
		@(negedge clk);
	endtask

	task automatic wait_run();
		int n;
		n = 0;
		@(negedge clk);
		while (!cpu_reset_n_o && n < RUN_TIMEOUT) begin
			pulse_sof();
			n++;
		end
		if (!cpu_reset_n_o) begin
			errors++;
			$display("cpu reset still active after %0d frames", RUN_TIMEOUT);
		end
	endtask

	// cpu reset must hold until the last counted frame
	task automatic check_release();
		int f;
		repeat (2) @(posedge clk);
		for (f = 1; f <= RESET_FRAMES; f++) begin
			pulse_sof();
			if (f < RESET_FRAMES && cpu_reset_n_o !== 1'b0)
				report_mismatch("cpu_reset_n_o", cpu_reset_n_o, 1'b0);
			if (f == RESET_FRAMES && cpu_reset_n_o !== 1'b1)
				report_mismatch("cpu_reset_n_o", cpu_reset_n_o, 1'b1);
		end
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		wb_data_t rd;
		wb_data_t wd;
		logic     prev;
		int       n_cen;
		clk = 1'b0;
		reset = 1'b1;
		seed = 32'd79714;
		{wb_cyc_i, wb_stb_i, wb_we_i} = 3'b000;
		wb_adr_i = '0;
		wb_dat_i = '0;
		rtc_i = '0;
		ovl_i = 1'b1;
		{ext_rst_i, kbd_rst_i, sof_i} = 3'b000;
		kbd_reset_n_i = 1'b1;
		cpu_reset_in_n_i = 1'b1;
		irq_req_i = '0;
		{nmi_i, hblank_i, led_n_i} = 3'b000;
		vsync_n_i = 1'b1;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		// register readback, truncated to each field
		for (int r = 0; r < 4; r++) begin
			for (int i = 0; i <= 5; i++) begin
				seed = xorshift(seed);
				wb_write(wb_adr_t'(i), seed[15:0]);
				wb_read(wb_adr_t'(i), rd);
				if (rd !== (seed[15:0] & read_mask(wb_adr_t'(i))))
					report_mismatch("wb_dat_o", rd, seed[15:0] & read_mask(wb_adr_t'(i)));
			end
		end
		// holes and rtc window drop writes and read zero or rtc
		for (int i = 6; i < 16; i++) begin
			seed = xorshift(seed);
			wb_write(wb_adr_t'(i), seed[15:0]);
		end
		seed = xorshift(seed);
		rtc_i[31:0] <= seed;
		seed = xorshift(seed);
		rtc_i[63:32] <= seed;
		for (int i = 6; i < 16; i++) begin
			wb_read(wb_adr_t'(i), rd);
			wd = (i >= 8 && i < 12) ? rtc_i[16 * (i - 8) +: 16] : 16'h0000;
			if (rd !== wd) report_mismatch("wb_dat_o", rd, wd);
		end

		// derived flags under both overlay states
		for (int i = 0; i < 16; i++) begin
			seed = xorshift(seed);
			wb_write(REG_MEMORY, seed[15:0]);
			wb_write(REG_CPU, seed[31:16]);
			wb_write(REG_CHIPSET, {seed[7:0], seed[23:16]});
			@(posedge clk) ovl_i <= 1'b0;
			repeat (2) @(posedge clk);
			ovl_i <= 1'b1;
			repeat (2) @(posedge clk);
		end
		ovl_i <= 1'b0;

		// reset sources, each followed by the frame count
		wait_run();
		@(posedge clk) ext_rst_i <= 1'b1;
		repeat (3) @(posedge clk);
		ext_rst_i <= 1'b0;
		check_release();
		@(posedge clk) kbd_rst_i <= 1'b1;
		repeat (3) @(posedge clk);
		kbd_rst_i <= 1'b0;
		check_release();
		@(posedge clk) kbd_reset_n_i <= 1'b0;
		repeat (3) @(posedge clk);
		kbd_reset_n_i <= 1'b1;
		check_release();
		wb_write(REG_MISC, 16'h0001);  // user reset
		check_release();
		// cpu core stretches the global reset
		@(posedge clk) cpu_reset_in_n_i <= 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		if (rst_o !== 1'b1) report_mismatch("rst_o", rst_o, 1'b1);
		if (cpu_reset_n_o !== 1'b1) report_mismatch("cpu_reset_n_o", cpu_reset_n_o, 1'b1);
		@(posedge clk) cpu_reset_in_n_i <= 1'b1;
		@(negedge clk);
		if (rst_o !== 1'b0) report_mismatch("rst_o", rst_o, 1'b0);

		// sample enable rate, exact timing checked by the compare process
		n_cen = 0;
		repeat (5000) begin
			@(negedge clk);
			if (cen_44100_o)
				n_cen++;
		end
		if (n_cen < 5000 * SAMPLE_HZ / CLK_HZ - 1 || n_cen > 5000 * SAMPLE_HZ / CLK_HZ + 1)
			report_mismatch("cen_44100_o pulse count", n_cen, 5000 * SAMPLE_HZ / CLK_HZ);

		// vsync toggle, one flip per falling edge
		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			prev = init_b_o;
			@(posedge clk) vsync_n_i <= 1'b0;
			repeat (4) @(posedge clk);
			vsync_n_i <= 1'b1;
			repeat (4) @(posedge clk);
			@(negedge clk);
			if (init_b_o !== ~prev) report_mismatch("init_b_o", init_b_o, ~prev);
		end

		// ntsc bit ignored while running, taken during reset
		@(negedge clk);
		prev = ntsc_o;
		wb_write(REG_CHIPSET, {14'd0, ~prev, 1'b0});
		repeat (3) @(negedge clk);
		if (ntsc_o !== prev) report_mismatch("ntsc_o", ntsc_o, prev);
		@(posedge clk) ext_rst_i <= 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		if (ntsc_o !== ~prev) report_mismatch("ntsc_o", ntsc_o, ~prev);
		@(posedge clk) ext_rst_i <= 1'b0;
		wait_run();

		// led dimming on and off, led and hblank run in the background
		for (int i = 0; i < 12; i++) begin
			seed = xorshift(seed);
			wb_write(REG_MISC, {14'd0, seed[9], 1'b0});
			repeat (8) @(posedge clk);
		end

		repeat (5) @(posedge clk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
src/glue_pkg.sv
src/wb_reg_port.sv
src/config_regs.sv
src/sys_reset_ctrl.sv
src/audio_rate_gen.sv
src/irq_prio.sv
src/video_status.sv
src/minimig_glue.sv
dv/tb_minimig_glue.sv

/* src/audio_rate_gen.sv */
// sample rate enable generator
// fractional accumulator, average rate SAMPLE_HZ out of CLK_HZ
`timescale 1ns/1ns
`default_nettype none

module audio_rate_gen #(
	parameter int unsigned CLK_HZ    = 28_000_000,
	parameter int unsigned SAMPLE_HZ = 44_100
) (
	input  wire  clk,
	input  wire  reset,
	output logic cen_44100_o
);

	logic [31:0] acc;
	logic [31:0] acc_next;

	assign acc_next = acc + 32'(SAMPLE_HZ);

	// remainder carried over, so no drift over time
	always_ff @(posedge clk) begin
		if (reset) begin
			acc         <= '0;
			cen_44100_o <= 1'b0;
		end else if (acc_next >= 32'(CLK_HZ)) begin
			acc         <= acc_next - 32'(CLK_HZ);  // wrap
			cen_44100_o <= 1'b1;
		end else begin
			acc         <= acc_next;
			cen_44100_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* src/config_regs.sv */
// configuration register bank
// memory, chipset, cpu, floppy, ide and misc words plus derived turbo flags
`timescale 1ns/1ns
`default_nettype none

module config_regs
	import glue_pkg::*;
(
	input  wire          clk,
	input  wire          reset,
	input  wire          cfg_wr_i,
	input  wire  [2:0]   cfg_idx_i,
	input  wb_data_t     cfg_wdat_i,
	input  wire          ovl_i,            // kickstart overlay active
	output wb_data_t     cfg_rdat_o,
	output mem_cfg_t     memory_config_o,
	output chipset_cfg_t chipset_config_o,
	output cpu_cfg_t     cpu_config_o,
	output floppy_cfg_t  floppy_config_o,
	output ide_cfg_t     ide_config0_o,
	output ide_cfg_t     ide_config1_o,
	output logic         usr_rst_o,
	output logic         led_dim_n_o,
	output logic         turbochipram_o,
	output logic         turbokick_o,
	output logic         aga_o,
	output logic [1:0]   slow_config_o
);

	wb_adr_t idx;  // index widened to the register map
	assign idx = {1'b0, cfg_idx_i};

	//--------------------------------------------------------------------------
	// register writes
	//--------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			memory_config_o  <= '0;
			chipset_config_o <= '0;
			cpu_config_o     <= '0;
			floppy_config_o  <= '0;
			ide_config0_o    <= '0;
			ide_config1_o    <= '0;
			led_dim_n_o      <= 1'b0;
			usr_rst_o        <= 1'b0;
		end else begin
			usr_rst_o <= 1'b0;  // single cycle pulse
			if (cfg_wr_i) begin
				case (idx)
					REG_MEMORY:  memory_config_o  <= cfg_wdat_i[6:0];
					REG_CHIPSET: chipset_config_o <= cfg_wdat_i[4:0];
					REG_CPU:     cpu_config_o     <= cfg_wdat_i[3:0];
					REG_FLOPPY:  floppy_config_o  <= cfg_wdat_i[3:0];
					REG_IDE: begin
						ide_config0_o <= cfg_wdat_i[2:0];
						ide_config1_o <= cfg_wdat_i[5:3];
					end
					REG_MISC: begin
						usr_rst_o   <= cfg_wdat_i[0];  // self clearing
						led_dim_n_o <= cfg_wdat_i[1];
					end
					default: ;  // 6 and 7 are holes
				endcase
			end
		end
	end

	//--------------------------------------------------------------------------
	// readback
	//--------------------------------------------------------------------------
	always_comb begin
		case (idx)
			REG_MEMORY:  cfg_rdat_o = {9'd0, memory_config_o};
			REG_CHIPSET: cfg_rdat_o = {11'd0, chipset_config_o};
			REG_CPU:     cfg_rdat_o = {12'd0, cpu_config_o};
			REG_FLOPPY:  cfg_rdat_o = {12'd0, floppy_config_o};
			REG_IDE:     cfg_rdat_o = {10'd0, ide_config1_o, ide_config0_o};
			REG_MISC:    cfg_rdat_o = {14'd0, led_dim_n_o, 1'b0};  // reset bit reads 0
			default:     cfg_rdat_o = '0;
		endcase
	end

	//--------------------------------------------------------------------------
	// derived flags
	//--------------------------------------------------------------------------
	// turbo chip needs fast chip and a full 2MB chip ram, never under overlay
	assign turbochipram_o = ~ovl_i & cpu_config_o[2] & (&memory_config_o[1:0]);
	assign turbokick_o    = ~ovl_i & cpu_config_o[3];  // fast kick
	assign aga_o          = chipset_config_o[4];
	assign slow_config_o  = memory_config_o[3:2];

endmodule

`default_nettype wire

/* src/glue_pkg.sv */
// system glue shared definitions
// register map, configuration word types and reset sequencer states
`default_nettype none

package glue_pkg;

	// ------------------------------------------------------------------------
	// host register port
	// ------------------------------------------------------------------------
	typedef logic [3:0]  wb_adr_t;   // register word address
	typedef logic [15:0] wb_data_t;  // register data word

	// ------------------------------------------------------------------------
	// configuration words
	// ------------------------------------------------------------------------
	typedef logic [6:0] mem_cfg_t;      // [1:0] chip, [3:2] slow, [5:4] fast, [6] monitor
	typedef logic [4:0] chipset_cfg_t;  // [1] ntsc, [2] a1000, [3] ecs, [4] aga
	typedef logic [3:0] cpu_cfg_t;      // [2] fast chip, [3] fast kick
	typedef logic [3:0] floppy_cfg_t;   // drive count and speed
	typedef logic [2:0] ide_cfg_t;      // one channel: enable, master, slave

	typedef logic [2:0] ipl_t;  // m68k interrupt level code

	// register word indices
	localparam wb_adr_t REG_MEMORY  = 4'd0;
	localparam wb_adr_t REG_CHIPSET = 4'd1;
	localparam wb_adr_t REG_CPU     = 4'd2;
	localparam wb_adr_t REG_FLOPPY  = 4'd3;
	localparam wb_adr_t REG_IDE     = 4'd4;  // ch0 in [2:0], ch1 in [5:3]
	localparam wb_adr_t REG_MISC    = 4'd5;  // [0] user reset, [1] led dim enable (low)
	localparam wb_adr_t REG_RTC0    = 4'd8;  // words 8..11 map rtc bits 16k+15..16k

	// system reset sequencer
	typedef enum logic [1:0] {
		RST_HOLD,   // a reset source is active
		RST_COUNT,  // released, waiting for frames
		RST_RUN     // system running
	} rst_state_t;

endpackage

`default_nettype wire

/* src/irq_prio.sv */
// cpu interrupt level encoder
// highest pending level wins, nmi forces level 7, registered active low
`timescale 1ns/1ns
`default_nettype none

module irq_prio
	import glue_pkg::*;
(
	input  wire        clk,
	input  wire        reset,
	input  wire  [5:0] irq_req_i,  // bit k-1 requests level k
	input  wire        nmi_i,      // level 7, from the cartridge
	output ipl_t       ipl_n_o
);

	ipl_t level;  // highest active level, 0 when idle

	always_comb begin
		level = '0;
		// ascending scan, the last hit is the highest level
		for (int k = 0; k < 6; k++) begin
			if (irq_req_i[k])
				level = ipl_t'(k + 1);
		end
		if (nmi_i)
			level = 3'd7;  // overrides everything
	end

	always_ff @(posedge clk) begin
		if (reset)
			ipl_n_o <= 3'b111;  // no request
		else
			ipl_n_o <= ~level;
	end

endmodule

`default_nettype wire

/* src/minimig_glue.sv */
// system glue top level
// host registers, reset sequencing, sample timing, interrupts and video status
`timescale 1ns/1ns
`default_nettype none

module minimig_glue
	import glue_pkg::*;
#(
	parameter int unsigned CLK_HZ       = 28_000_000,
	parameter int unsigned SAMPLE_HZ    = 44_100,
	parameter int unsigned RESET_FRAMES = 3,
	parameter bit          NTSC_DEFAULT = 1'b0
) (
	input  wire          clk,
	input  wire          reset,
	// host port
	input  wire          wb_cyc_i,
	input  wire          wb_stb_i,
	input  wire          wb_we_i,
	input  wb_adr_t      wb_adr_i,
	input  wb_data_t     wb_dat_i,
	output logic         wb_ack_o,
	output wb_data_t     wb_dat_o,
	input  wire  [63:0]  rtc_i,
	// configuration
	input  wire          ovl_i,
	output mem_cfg_t     memory_config_o,
	output chipset_cfg_t chipset_config_o,
	output cpu_cfg_t     cpu_config_o,
	output floppy_cfg_t  floppy_config_o,
	output ide_cfg_t     ide_config0_o,
	output ide_cfg_t     ide_config1_o,
	output logic         turbochipram_o,
	output logic         turbokick_o,
	output logic         aga_o,
	output logic [1:0]   slow_config_o,
	// reset
	input  wire          ext_rst_i,
	input  wire          kbd_rst_i,
	input  wire          kbd_reset_n_i,
	input  wire          cpu_reset_in_n_i,
	input  wire          sof_i,
	output logic         rst_o,
	output logic         cpu_reset_n_o,
	// audio timing
	output logic         cen_44100_o,
	// interrupts
	input  wire  [5:0]   irq_req_i,
	input  wire          nmi_i,
	output ipl_t         ipl_n_o,
	// video status
	input  wire          vsync_n_i,
	input  wire          hblank_i,
	input  wire          led_n_i,
	output logic         init_b_o,
	output logic         ntsc_o,
	output logic         pwr_led_o
);

	logic       cfg_wr;
	logic [2:0] cfg_idx;
	wb_data_t   cfg_wdat;
	wb_data_t   cfg_rdat;
	logic       usr_rst;    // register requested reset
	logic       led_dim_n;

	//--------------------------------------------------------------------------
	// configuration
	//--------------------------------------------------------------------------
	wb_reg_port wb_reg_port_i (
		.clk        (clk),
		.reset      (reset),
		.wb_cyc_i   (wb_cyc_i),
		.wb_stb_i   (wb_stb_i),
		.wb_we_i    (wb_we_i),
		.wb_adr_i   (wb_adr_i),
		.wb_dat_i   (wb_dat_i),
		.wb_ack_o   (wb_ack_o),
		.wb_dat_o   (wb_dat_o),
		.rtc_i      (rtc_i),
		.cfg_wr_o   (cfg_wr),
		.cfg_idx_o  (cfg_idx),
		.cfg_wdat_o (cfg_wdat),
		.cfg_rdat_i (cfg_rdat)
	);

	config_regs config_regs_i (
		.clk              (clk),
		.reset            (reset),
		.cfg_wr_i         (cfg_wr),
		.cfg_idx_i        (cfg_idx),
		.cfg_wdat_i       (cfg_wdat),
		.ovl_i            (ovl_i),
		.cfg_rdat_o       (cfg_rdat),
		.memory_config_o  (memory_config_o),
		.chipset_config_o (chipset_config_o),
		.cpu_config_o     (cpu_config_o),
		.floppy_config_o  (floppy_config_o),
		.ide_config0_o    (ide_config0_o),
		.ide_config1_o    (ide_config1_o),
		.usr_rst_o        (usr_rst),
		.led_dim_n_o      (led_dim_n),
		.turbochipram_o   (turbochipram_o),
		.turbokick_o      (turbokick_o),
		.aga_o            (aga_o),
		.slow_config_o    (slow_config_o)
	);

	//--------------------------------------------------------------------------
	// reset, timing, interrupts, video
	//--------------------------------------------------------------------------
	sys_reset_ctrl #(
		.RESET_FRAMES (RESET_FRAMES)
	) sys_reset_ctrl_i (
		.clk              (clk),
		.reset            (reset),
		.ext_rst_i        (ext_rst_i),
		.kbd_rst_i        (kbd_rst_i),
		.usr_rst_i        (usr_rst),
		.kbd_reset_n_i    (kbd_reset_n_i),
		.cpu_reset_in_n_i (cpu_reset_in_n_i),
		.sof_i            (sof_i),
		.sys_rst_o        (rst_o),
		.cpu_reset_n_o    (cpu_reset_n_o)
	);

	audio_rate_gen #(
		.CLK_HZ    (CLK_HZ),
		.SAMPLE_HZ (SAMPLE_HZ)
	) audio_rate_gen_i (
		.clk         (clk),
		.reset       (reset),
		.cen_44100_o (cen_44100_o)
	);

	irq_prio irq_prio_i (
		.clk       (clk),
		.reset     (reset),
		.irq_req_i (irq_req_i),
		.nmi_i     (nmi_i),
		.ipl_n_o   (ipl_n_o)
	);

	video_status #(
		.NTSC_DEFAULT (NTSC_DEFAULT)
	) video_status_i (
		.clk         (clk),
		.reset       (reset),
		.sys_rst_i   (rst_o),                // global reset latches the mode
		.vsync_n_i   (vsync_n_i),
		.hblank_i    (hblank_i),
		.led_n_i     (led_n_i),
		.led_dim_n_i (led_dim_n),
		.ntsc_cfg_i  (chipset_config_o[1]),  // ntsc bit
		.init_b_o    (init_b_o),
		.ntsc_o      (ntsc_o),
		.pwr_led_o   (pwr_led_o)
	);

endmodule

`default_nettype wire

/* src/sys_reset_ctrl.sv */
// system reset sequencer
// holds the machine in reset while any source is active, then for some frames
`timescale 1ns/1ns
`default_nettype none

module sys_reset_ctrl
	import glue_pkg::*;
#(
	parameter int unsigned RESET_FRAMES = 3
) (
	input  wire  clk,
	input  wire  reset,
	input  wire  ext_rst_i,         // from the control block
	input  wire  kbd_rst_i,         // keyboard reset combo
	input  wire  usr_rst_i,         // register write
	input  wire  kbd_reset_n_i,     // keyboard reset line, active low
	input  wire  cpu_reset_in_n_i,  // cpu core still in reset when low
	input  wire  sof_i,             // start of frame
	output logic sys_rst_o,
	output logic cpu_reset_n_o
);

	localparam int CNT_W = $clog2(RESET_FRAMES + 1);

	rst_state_t       state;
	logic [CNT_W-1:0] frames;   // sof pulses seen since release
	logic             rst_req;  // any source asking for reset

	assign rst_req = ext_rst_i | kbd_rst_i | usr_rst_i | ~kbd_reset_n_i;

	//--------------------------------------------------------------------------
	// sequencer
	//--------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state  <= RST_HOLD;
			frames <= '0;
		end else if (rst_req) begin
			state  <= RST_HOLD;  // restart from any state
			frames <= '0;
		end else begin
			case (state)
				RST_HOLD: state <= RST_COUNT;
				RST_COUNT: begin
					if (sof_i) begin
						frames <= frames + 1'b1;
						if (frames == CNT_W'(RESET_FRAMES - 1))
							state <= RST_RUN;  // last frame seen
					end
				end
				default: state <= RST_RUN;
			endcase
		end
	end

	assign cpu_reset_n_o = (state == RST_RUN);
	// cpu core may stretch the global reset, never shorten it
	assign sys_rst_o = (state != RST_RUN) | ~cpu_reset_in_n_i;

endmodule

`default_nettype wire

/* src/video_status.sv */
// video status glue
// mcu vsync toggle, pal/ntsc latch during reset, dimmable power led
`timescale 1ns/1ns
`default_nettype none

module video_status #(
	parameter bit NTSC_DEFAULT = 1'b0
) (
	input  wire  clk,
	input  wire  reset,
	input  wire  sys_rst_i,    // global reset
	input  wire  vsync_n_i,
	input  wire  hblank_i,
	input  wire  led_n_i,      // power led request, active low
	input  wire  led_dim_n_i,  // dim at off state when low
	input  wire  ntsc_cfg_i,   // chipset config ntsc bit
	output logic init_b_o,
	output logic ntsc_o,
	output logic pwr_led_o
);

	logic vsync_s;    // sampled vsync
	logic vsync_del;  // previous sample

	//--------------------------------------------------------------------------
	// vsync toggle for the mcu
	//--------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_s   <= 1'b1;  // sync idles high
			vsync_del <= 1'b1;
			init_b_o  <= 1'b0;
		end else begin
			vsync_s   <= vsync_n_i;
			vsync_del <= vsync_s;
			if (~vsync_s & vsync_del)
				init_b_o <= ~init_b_o;  // once per frame
		end
	end

	// video mode only changes under reset
	always_ff @(posedge clk) begin
		if (reset)
			ntsc_o <= NTSC_DEFAULT;
		else if (sys_rst_i)
			ntsc_o <= ntsc_cfg_i;
	end

	//--------------------------------------------------------------------------
	// power led
	//--------------------------------------------------------------------------
	// dimmed off state lights the led during hblank only
	assign pwr_led_o = led_dim_n_i ? ~led_n_i : ~(led_n_i & ~hblank_i);

endmodule

`default_nettype wire

/* src/wb_reg_port.sv */
// wishbone classic slave for the glue registers
// single cycle ack, address split into config words, rtc window and holes
`timescale 1ns/1ns
`default_nettype none

module wb_reg_port
	import glue_pkg::*;
(
	input  wire         clk,
	input  wire         reset,
	// wishbone slave
	input  wire         wb_cyc_i,
	input  wire         wb_stb_i,
	input  wire         wb_we_i,
	input  wb_adr_t     wb_adr_i,
	input  wb_data_t    wb_dat_i,
	output logic        wb_ack_o,
	output wb_data_t    wb_dat_o,
	// real time clock, read only
	input  wire  [63:0] rtc_i,
	// configuration register bank
	output logic        cfg_wr_o,
	output logic [2:0]  cfg_idx_o,
	output wb_data_t    cfg_wdat_o,
	input  wb_data_t    cfg_rdat_i
);

	logic       req;       // new request, not yet acked
	logic       in_cfg;    // address hits a config word
	logic       in_rtc;    // address hits the rtc window
	logic [1:0] rtc_word;  // 16 bit slice select
	wb_data_t   rd_mux;

	//--------------------------------------------------------------------------
	// address decode
	//--------------------------------------------------------------------------
	assign req      = wb_cyc_i & wb_stb_i & ~wb_ack_o;
	assign in_cfg   = (wb_adr_i <= REG_MISC);
	assign in_rtc   = (wb_adr_i[3:2] == REG_RTC0[3:2]);  // words 8..11
	assign rtc_word = wb_adr_i[1:0];

	// config bank sees the request directly, writes land on the ack edge
	assign cfg_idx_o  = wb_adr_i[2:0];
	assign cfg_wdat_o = wb_dat_i;
	assign cfg_wr_o   = req & wb_we_i & in_cfg;  // rtc and holes drop writes

	always_comb begin
		if (in_cfg)
			rd_mux = cfg_rdat_i;
		else if (in_rtc)
			rd_mux = rtc_i[{rtc_word, 4'b0000} +: 16];
		else
			rd_mux = '0;  // unmapped reads as zero
	end

	//--------------------------------------------------------------------------
	// handshake
	//--------------------------------------------------------------------------
	// no wait states, ack one cycle after the strobe is seen
	always_ff @(posedge clk) begin
		if (reset)
			wb_ack_o <= 1'b0;
		else
			wb_ack_o <= req;
	end

	// read data captured with ack
	always_ff @(posedge clk) begin
		if (req)
			wb_dat_o <= rd_mux;
	end

endmodule

`default_nettype wire
